// File: decoder_pkg.sv
package decoder_pkg;

  // raw fetched instruction word
  typedef logic [31:0] instr_t;

  // opcode without the two low quadrant bits, which are checked separately
  typedef logic [4:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // control words handed to the datapath
  typedef logic [4:0]  alu_op_t;
  typedef logic [1:0]  a_sel_t;
  typedef logic [2:0]  b_sel_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [2:0]  mem_size_t;
  typedef logic [2:0]  csr_op_t;

  // arithmetic and logic codes, bit 3 marks the alternate form (sub, sra)
  localparam alu_op_t ALU_ADD  = 5'b00000;
  localparam alu_op_t ALU_SUB  = 5'b01000;
  localparam alu_op_t ALU_SLL  = 5'b00001;
  localparam alu_op_t ALU_SLTS = 5'b00010;
  localparam alu_op_t ALU_SLTU = 5'b00011;
  localparam alu_op_t ALU_XOR  = 5'b00100;
  localparam alu_op_t ALU_SRL  = 5'b00101;
  localparam alu_op_t ALU_SRA  = 5'b01101;
  localparam alu_op_t ALU_OR   = 5'b00110;
  localparam alu_op_t ALU_AND  = 5'b00111;

  // compare codes are 2'b11 followed by the branch funct3
  localparam alu_op_t ALU_EQ   = 5'b11000;
  localparam alu_op_t ALU_NE   = 5'b11001;
  localparam alu_op_t ALU_LTS  = 5'b11100;
  localparam alu_op_t ALU_GES  = 5'b11101;
  localparam alu_op_t ALU_LTU  = 5'b11110;
  localparam alu_op_t ALU_GEU  = 5'b11111;

  // first ALU operand comes from rs1, the current pc or a hard zero
  localparam a_sel_t OP_A_RS1     = 2'd0;
  localparam a_sel_t OP_A_CURR_PC = 2'd1;
  localparam a_sel_t OP_A_ZERO    = 2'd2;

  // second ALU operand, OP_B_INCR is the constant 4 used for return addresses
  localparam b_sel_t OP_B_RS2   = 3'd0;
  localparam b_sel_t OP_B_IMM_I = 3'd1;
  localparam b_sel_t OP_B_IMM_U = 3'd2;
  localparam b_sel_t OP_B_IMM_S = 3'd3;
  localparam b_sel_t OP_B_INCR  = 3'd4;

  // source of the register file write data
  localparam wb_sel_t WB_EX_RESULT = 2'd0;
  localparam wb_sel_t WB_LSU_DATA  = 2'd1;
  localparam wb_sel_t WB_CSR_DATA  = 2'd2;

  // access sizes match the load/store funct3 encodings one to one
  localparam mem_size_t LDST_B  = 3'd0;
  localparam mem_size_t LDST_H  = 3'd1;
  localparam mem_size_t LDST_W  = 3'd2;
  localparam mem_size_t LDST_BU = 3'd4;
  localparam mem_size_t LDST_HU = 3'd5;

  // CSR operations match the system funct3 encodings, 0 and 4 are unused
  localparam csr_op_t CSR_RW  = 3'd1;
  localparam csr_op_t CSR_RS  = 3'd2;
  localparam csr_op_t CSR_RC  = 3'd3;
  localparam csr_op_t CSR_RWI = 3'd5;
  localparam csr_op_t CSR_RSI = 3'd6;
  localparam csr_op_t CSR_RCI = 3'd7;

  // major opcodes, bits 6 to 2 of the instruction
  localparam opcode_t LOAD_OPCODE     = 5'b00000;
  localparam opcode_t MISC_MEM_OPCODE = 5'b00011;
  localparam opcode_t OP_IMM_OPCODE   = 5'b00100;
  localparam opcode_t AUIPC_OPCODE    = 5'b00101;
  localparam opcode_t STORE_OPCODE    = 5'b01000;
  localparam opcode_t OP_OPCODE       = 5'b01100;
  localparam opcode_t LUI_OPCODE      = 5'b01101;
  localparam opcode_t BRANCH_OPCODE   = 5'b11000;
  localparam opcode_t JALR_OPCODE     = 5'b11001;
  localparam opcode_t JAL_OPCODE      = 5'b11011;
  localparam opcode_t SYSTEM_OPCODE   = 5'b11100;

  // funct7 forms, alt sets bit 5 to select sub and sra
  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;

  // mret is matched on the complete word, rs1, rd and rs2 fields included
  localparam instr_t MRET_INSTR = 32'h3020_0073;

endpackage

// File: mem_access_decoder.sv
module mem_access_decoder
  import decoder_pkg::*;
(
  input  opcode_t   opcode_i,
  input  funct3_t   funct3_i,
  input  funct7_t   funct7_i,
  output logic      hit_o,
  output logic      illegal_o,
  output logic      mem_req_o,
  output logic      mem_we_o,
  output logic      gpr_we_o,
  output wb_sel_t   wb_sel_o,
  output b_sel_t    b_sel_o,
  output mem_size_t mem_size_o
);

  // the address is always rs1 plus an immediate, so only operand b differs
  // between the two opcodes and operand a keeps its default
  always_comb begin
    hit_o      = 1'b0;
    illegal_o  = 1'b0;
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    gpr_we_o   = 1'b0;
    wb_sel_o   = WB_EX_RESULT;
    b_sel_o    = OP_B_RS2;
    mem_size_o = '0;
    case (opcode_i)
      STORE_OPCODE: begin
        hit_o   = 1'b1;
        // store offset is split between funct7 and the rd field
        b_sel_o = OP_B_IMM_S;
        case (funct3_i)
          LDST_B, LDST_H, LDST_W: begin
            mem_req_o  = 1'b1;
            mem_we_o   = 1'b1;
            mem_size_o = funct3_i;
          end
          // unsigned forms make no sense for a store
          default: illegal_o = 1'b1;
        endcase
      end
      LOAD_OPCODE: begin
        hit_o    = 1'b1;
        b_sel_o  = OP_B_IMM_I;
        wb_sel_o = WB_LSU_DATA;
        case (funct3_i)
          LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU: begin
            mem_req_o  = 1'b1;
            gpr_we_o   = 1'b1;
            mem_size_o = funct3_i;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      // not a memory opcode, everything stays at the default
      default: ;
    endcase
  end

endmodule

// File: control_flow_decoder.sv
module control_flow_decoder
  import decoder_pkg::*;
(
  input  opcode_t opcode_i,
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  output logic    hit_o,
  output logic    illegal_o,
  output logic    branch_o,
  output logic    jal_o,
  output logic    jalr_o,
  output logic    gpr_we_o,
  output a_sel_t  a_sel_o,
  output b_sel_t  b_sel_o,
  output alu_op_t alu_op_o
);

  // the branch funct3 lands directly in the low bits of the compare code
  alu_op_t cmp_op;

  assign cmp_op = {2'b11, funct3_i};

  always_comb begin
    hit_o     = 1'b0;
    illegal_o = 1'b0;
    branch_o  = 1'b0;
    jal_o     = 1'b0;
    jalr_o    = 1'b0;
    gpr_we_o  = 1'b0;
    a_sel_o   = OP_A_RS1;
    b_sel_o   = OP_B_RS2;
    alu_op_o  = ALU_ADD;
    case (opcode_i)
      BRANCH_OPCODE: begin
        hit_o    = 1'b1;
        // rs1 against rs2, the target adder outside the ALU uses the B-immediate
        alu_op_o = cmp_op;
        case (cmp_op)
          ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU: branch_o = 1'b1;
          // funct3 of 2 or 3 has no compare behind it
          default: illegal_o = 1'b1;
        endcase
      end
      JAL_OPCODE: begin
        hit_o    = 1'b1;
        jal_o    = 1'b1;
        // the ALU builds the link address pc + 4 for rd
        gpr_we_o = 1'b1;
        a_sel_o  = OP_A_CURR_PC;
        b_sel_o  = OP_B_INCR;
      end
      JALR_OPCODE: begin
        hit_o = 1'b1;
        if (funct3_i == 3'd0) begin
          jalr_o   = 1'b1;
          gpr_we_o = 1'b1;
          a_sel_o  = OP_A_CURR_PC;
          b_sel_o  = OP_B_INCR;
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: alu_op_decoder.sv
module alu_op_decoder
  import decoder_pkg::*;
(
  input  opcode_t opcode_i,
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  output logic    hit_o,
  output logic    illegal_o,
  output logic    gpr_we_o,
  output a_sel_t  a_sel_o,
  output b_sel_t  b_sel_o,
  output alu_op_t alu_op_o
);

  // plain operation for a funct3, shared by the register and immediate forms
  function automatic alu_op_t base_alu_op(input funct3_t funct3);
    alu_op_t op;
    case (funct3)
      3'd0:    op = ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLTS;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    hit_o     = 1'b0;
    illegal_o = 1'b0;
    gpr_we_o  = 1'b0;
    a_sel_o   = OP_A_RS1;
    b_sel_o   = OP_B_RS2;
    alu_op_o  = ALU_ADD;
    case (opcode_i)
      OP_OPCODE: begin
        hit_o    = 1'b1;
        gpr_we_o = 1'b1;
        case (funct7_i)
          FUNCT7_BASE: alu_op_o = base_alu_op(funct3_i);
          FUNCT7_ALT: begin
            // only sub and sra have an alternate encoding
            if (funct3_i == 3'd0) alu_op_o = ALU_SUB;
            else if (funct3_i == 3'd5) alu_op_o = ALU_SRA;
            else illegal_o = 1'b1;
          end
          default: illegal_o = 1'b1;
        endcase
      end
      OP_IMM_OPCODE: begin
        hit_o    = 1'b1;
        gpr_we_o = 1'b1;
        b_sel_o  = OP_B_IMM_I;
        // funct7 is part of the immediate except for shifts, where it holds the form
        case (funct3_i)
          3'd1: begin
            if (funct7_i == FUNCT7_BASE) alu_op_o = ALU_SLL;
            else illegal_o = 1'b1;
          end
          3'd5: begin
            if (funct7_i == FUNCT7_BASE) alu_op_o = ALU_SRL;
            else if (funct7_i == FUNCT7_ALT) alu_op_o = ALU_SRA;
            else illegal_o = 1'b1;
          end
          default: alu_op_o = base_alu_op(funct3_i);
        endcase
      end
      LUI_OPCODE: begin
        hit_o    = 1'b1;
        gpr_we_o = 1'b1;
        // zero plus the upper immediate
        a_sel_o  = OP_A_ZERO;
        b_sel_o  = OP_B_IMM_U;
      end
      AUIPC_OPCODE: begin
        hit_o    = 1'b1;
        gpr_we_o = 1'b1;
        a_sel_o  = OP_A_CURR_PC;
        b_sel_o  = OP_B_IMM_U;
      end
      MISC_MEM_OPCODE: begin
        hit_o = 1'b1;
        // fence runs as a harmless AND with nothing written back
        if (funct3_i == 3'd0) begin
          alu_op_o = ALU_AND;
          b_sel_o  = OP_B_IMM_I;
        end else begin
          illegal_o = 1'b1;
        end
      end
      default: ;
    endcase
    // a rejected encoding must not touch the register file
    if (illegal_o) gpr_we_o = 1'b0;
  end

endmodule

// File: system_decoder.sv
module system_decoder
  import decoder_pkg::*;
(
  input  instr_t  instr_i,
  input  opcode_t opcode_i,
  input  funct3_t funct3_i,
  input  funct7_t funct7_i,
  output logic    hit_o,
  output logic    illegal_o,
  output logic    gpr_we_o,
  output logic    csr_we_o,
  output logic    mret_o,
  output wb_sel_t wb_sel_o,
  output csr_op_t csr_op_o
);

  always_comb begin
    hit_o     = 1'b0;
    illegal_o = 1'b0;
    gpr_we_o  = 1'b0;
    csr_we_o  = 1'b0;
    mret_o    = 1'b0;
    wb_sel_o  = WB_EX_RESULT;
    csr_op_o  = '0;
    if (opcode_i == SYSTEM_OPCODE) begin
      hit_o = 1'b1;
      case (funct3_i)
        3'd0: begin
          // the privileged group shares funct3 zero, only mret is supported
          // and ecall, ebreak and anything else are trapped as illegal
          if (instr_i == MRET_INSTR) mret_o = 1'b1;
          else illegal_o = 1'b1;
        end
        CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI: begin
          // old CSR value goes to rd while the CSR unit applies funct3
          gpr_we_o = 1'b1;
          csr_we_o = 1'b1;
          wb_sel_o = WB_CSR_DATA;
          csr_op_o = funct3_i;
        end
        // funct3 of 4 is reserved
        default: illegal_o = 1'b1;
      endcase
    end
  end

endmodule

// File: decoder.sv
module decoder
  import decoder_pkg::*;
(
  input  instr_t    fetched_instr_i,
  output a_sel_t    a_sel_o,
  output b_sel_t    b_sel_o,
  output alu_op_t   alu_op_o,
  output csr_op_t   csr_op_o,
  output logic      csr_we_o,
  output logic      mem_req_o,
  output logic      mem_we_o,
  output mem_size_t mem_size_o,
  output logic      gpr_we_o,
  output wb_sel_t   wb_sel_o,
  output logic      illegal_instr_o,
  output logic      branch_o,
  output logic      jal_o,
  output logic      jalr_o,
  output logic      mret_o
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    quad_ok;

  // group outputs, prefixed mem_, cf_ (control flow), ar_ (arithmetic), sys_
  logic      mem_hit, mem_illegal, mem_req, mem_we, mem_gpr_we;
  wb_sel_t   mem_wb_sel;
  b_sel_t    mem_b_sel;
  mem_size_t mem_size;
  logic      cf_hit, cf_illegal, cf_branch, cf_jal, cf_jalr, cf_gpr_we;
  a_sel_t    cf_a_sel;
  b_sel_t    cf_b_sel;
  alu_op_t   cf_alu_op;
  logic      ar_hit, ar_illegal, ar_gpr_we;
  a_sel_t    ar_a_sel;
  b_sel_t    ar_b_sel;
  alu_op_t   ar_alu_op;
  logic      sys_hit, sys_illegal, sys_gpr_we, sys_csr_we, sys_mret;
  wb_sel_t   sys_wb_sel;
  csr_op_t   sys_csr_op;

  assign opcode  = fetched_instr_i[6:2];
  assign funct3  = fetched_instr_i[14:12];
  assign funct7  = fetched_instr_i[31:25];
  // compressed quadrants 00, 01 and 10 are not supported
  assign quad_ok = (fetched_instr_i[1:0] == 2'b11);

  mem_access_decoder u_mem (
    .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
    .hit_o(mem_hit), .illegal_o(mem_illegal), .mem_req_o(mem_req), .mem_we_o(mem_we),
    .gpr_we_o(mem_gpr_we), .wb_sel_o(mem_wb_sel), .b_sel_o(mem_b_sel), .mem_size_o(mem_size)
  );

  control_flow_decoder u_cf (
    .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
    .hit_o(cf_hit), .illegal_o(cf_illegal), .branch_o(cf_branch), .jal_o(cf_jal),
    .jalr_o(cf_jalr), .gpr_we_o(cf_gpr_we), .a_sel_o(cf_a_sel), .b_sel_o(cf_b_sel),
    .alu_op_o(cf_alu_op)
  );

  alu_op_decoder u_ar (
    .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
    .hit_o(ar_hit), .illegal_o(ar_illegal), .gpr_we_o(ar_gpr_we),
    .a_sel_o(ar_a_sel), .b_sel_o(ar_b_sel), .alu_op_o(ar_alu_op)
  );

  system_decoder u_sys (
    .instr_i(fetched_instr_i), .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
    .hit_o(sys_hit), .illegal_o(sys_illegal), .gpr_we_o(sys_gpr_we), .csr_we_o(sys_csr_we),
    .mret_o(sys_mret), .wb_sel_o(sys_wb_sel), .csr_op_o(sys_csr_op)
  );

  // opcodes are disjoint between groups, so the priority order below is arbitrary
  always_comb begin
    a_sel_o         = OP_A_RS1;
    b_sel_o         = OP_B_RS2;
    alu_op_o        = ALU_ADD;
    csr_op_o        = '0;
    csr_we_o        = 1'b0;
    mem_req_o       = 1'b0;
    mem_we_o        = 1'b0;
    mem_size_o      = '0;
    gpr_we_o        = 1'b0;
    wb_sel_o        = WB_EX_RESULT;
    illegal_instr_o = 1'b0;
    branch_o        = 1'b0;
    jal_o           = 1'b0;
    jalr_o          = 1'b0;
    mret_o          = 1'b0;
    if (!quad_ok || !(mem_hit || cf_hit || ar_hit || sys_hit)) begin
      illegal_instr_o = 1'b1;
    end else if (mem_hit) begin
      illegal_instr_o = mem_illegal;
      mem_req_o       = mem_req;
      mem_we_o        = mem_we;
      gpr_we_o        = mem_gpr_we;
      wb_sel_o        = mem_wb_sel;
      b_sel_o         = mem_b_sel;
      mem_size_o      = mem_size;
    end else if (cf_hit) begin
      illegal_instr_o = cf_illegal;
      branch_o        = cf_branch;
      jal_o           = cf_jal;
      jalr_o          = cf_jalr;
      gpr_we_o        = cf_gpr_we;
      a_sel_o         = cf_a_sel;
      b_sel_o         = cf_b_sel;
      alu_op_o        = cf_alu_op;
    end else if (ar_hit) begin
      illegal_instr_o = ar_illegal;
      gpr_we_o        = ar_gpr_we;
      a_sel_o         = ar_a_sel;
      b_sel_o         = ar_b_sel;
      alu_op_o        = ar_alu_op;
    end else begin
      illegal_instr_o = sys_illegal;
      gpr_we_o        = sys_gpr_we;
      csr_we_o        = sys_csr_we;
      mret_o          = sys_mret;
      wb_sel_o        = sys_wb_sel;
      csr_op_o        = sys_csr_op;
    end
  end

  // checks across the group decoders and the merge, evaluated once values settle
  always_comb begin
    assert final ($onehot0({mem_hit, cf_hit, ar_hit, sys_hit}))
      else $error("several group decoders claim opcode %b", opcode);
    assert final (!mem_we_o || mem_req_o)
      else $error("memory write enable without a memory request");
    assert final (!illegal_instr_o || !(gpr_we_o || mem_req_o || csr_we_o))
      else $error("illegal instruction %h still writes or requests", fetched_instr_i);
  end

endmodule

// File: tb_decoder.sv
module tb_decoder
  import decoder_pkg::*;
();

  localparam int    CLK_PERIOD  = 10;
  localparam int    RAND_COUNT  = 200;
  localparam int    MAX_VECTORS = 256;
  localparam int    NUM_FIELDS  = 16;
  localparam string VECTOR_FILE = "decoder_input.txt";
  // width of every column in the vector file, instruction first
  localparam int FIELD_BITS [NUM_FIELDS] = '{32, 2, 3, 5, 3, 1, 1, 1, 3, 1, 2, 1, 1, 1, 1, 1};

  logic      clk_i;
  logic      arst_n_i;
  instr_t    fetched_instr_i;
  a_sel_t    a_sel_o;
  b_sel_t    b_sel_o;
  alu_op_t   alu_op_o;
  csr_op_t   csr_op_o;
  logic      csr_we_o;
  logic      mem_req_o;
  logic      mem_we_o;
  mem_size_t mem_size_o;
  logic      gpr_we_o;
  wb_sel_t   wb_sel_o;
  logic      illegal_instr_o;
  logic      branch_o;
  logic      jal_o;
  logic      jalr_o;
  logic      mret_o;

  // each row holds one vector in file column order
  logic [31:0] vectors [MAX_VECTORS][NUM_FIELDS];
  int          num_vectors;
  bit          loaded;

  decoder dut_i (
    .fetched_instr_i(fetched_instr_i),
    .a_sel_o(a_sel_o),
    .b_sel_o(b_sel_o),
    .alu_op_o(alu_op_o),
    .csr_op_o(csr_op_o),
    .csr_we_o(csr_we_o),
    .mem_req_o(mem_req_o),
    .mem_we_o(mem_we_o),
    .mem_size_o(mem_size_o),
    .gpr_we_o(gpr_we_o),
    .wb_sel_o(wb_sel_o),
    .illegal_instr_o(illegal_instr_o),
    .branch_o(branch_o),
    .jal_o(jal_o),
    .jalr_o(jalr_o),
    .mret_o(mret_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // one compare task per DUT output type
  task automatic logic_equal(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic a_sel_equal(input string name, input a_sel_t exp, input a_sel_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic b_sel_equal(input string name, input b_sel_t exp, input b_sel_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic alu_op_equal(input string name, input alu_op_t exp, input alu_op_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic wb_sel_equal(input string name, input wb_sel_t exp, input wb_sel_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic mem_size_equal(input string name, input mem_size_t exp, input mem_size_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic csr_op_equal(input string name, input csr_op_t exp, input csr_op_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  // compares every DUT output against one row of expected values
  task automatic outputs_match(input logic [31:0] exp [NUM_FIELDS]);
    a_sel_equal("a_sel_o", a_sel_t'(exp[1]), a_sel_o);
    b_sel_equal("b_sel_o", b_sel_t'(exp[2]), b_sel_o);
    alu_op_equal("alu_op_o", alu_op_t'(exp[3]), alu_op_o);
    csr_op_equal("csr_op_o", csr_op_t'(exp[4]), csr_op_o);
    logic_equal("csr_we_o", exp[5][0], csr_we_o);
    logic_equal("mem_req_o", exp[6][0], mem_req_o);
    logic_equal("mem_we_o", exp[7][0], mem_we_o);
    mem_size_equal("mem_size_o", mem_size_t'(exp[8]), mem_size_o);
    logic_equal("gpr_we_o", exp[9][0], gpr_we_o);
    wb_sel_equal("wb_sel_o", wb_sel_t'(exp[10]), wb_sel_o);
    logic_equal("illegal_instr_o", exp[11][0], illegal_instr_o);
    logic_equal("branch_o", exp[12][0], branch_o);
    logic_equal("jal_o", exp[13][0], jal_o);
    logic_equal("jalr_o", exp[14][0], jalr_o);
    logic_equal("mret_o", exp[15][0], mret_o);
  endtask

  // inputs change just after the rising edge and are sampled at the falling edge
  task automatic drive_instr(input instr_t instr);
    @(posedge clk_i);
    #1;
    fetched_instr_i = instr;
    @(negedge clk_i);
  endtask

  task automatic load_vectors();
    int          fd;
    int          count;
    int          line_no;
    string       line;
    logic [31:0] fld [NUM_FIELDS];
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) abort_run($sformatf("cannot open vector file %s", VECTOR_FILE));
    line_no = 0;
    num_vectors = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      // blank lines and lines starting with # carry no vector
      if (line.len() <= 1 || line[0] == "#") continue;
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                      fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15]);
      if (count != NUM_FIELDS) begin
        abort_run($sformatf("line %0d of %s does not hold %0d hex fields",
                            line_no, VECTOR_FILE, NUM_FIELDS));
      end
      for (int k = 0; k < NUM_FIELDS; k++) begin
        if (FIELD_BITS[k] < 32 && (fld[k] >> FIELD_BITS[k]) != 0) begin
          abort_run($sformatf("line %0d of %s has field %0d out of range",
                              line_no, VECTOR_FILE, k));
        end
      end
      if (num_vectors == MAX_VECTORS) abort_run("vector file holds too many vectors");
      vectors[num_vectors] = fld;
      num_vectors++;
    end
    $fclose(fd);
    if (num_vectors == 0) abort_run($sformatf("no vectors found in %s", VECTOR_FILE));
  endtask

  // the decoder has no reset, so arst_n_i only holds off the first vector
  initial begin
    arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
  end

  initial begin
    logic [31:0] expected [NUM_FIELDS];
    instr_t      rand_instr;
    clk_i = 1'b0;
    fetched_instr_i = '0;
    void'($urandom(32'hc4cf_4c5d));
    load_vectors();
    loaded = 1'b1;
    wait (arst_n_i === 1'b1);
    for (int i = 0; i < num_vectors; i++) begin
      drive_instr(vectors[i][0]);
      outputs_match(vectors[i]);
    end
    // compressed quadrants must be illegal with every other output at its default
    for (int i = 0; i < RAND_COUNT; i++) begin
      rand_instr = $urandom();
      rand_instr[1:0] = 2'($urandom_range(2, 0));
      for (int k = 0; k < NUM_FIELDS; k++) expected[k] = '0;
      expected[0] = rand_instr;
      expected[1] = 32'(OP_A_RS1);
      expected[2] = 32'(OP_B_RS2);
      expected[3] = 32'(ALU_ADD);
      expected[10] = 32'(WB_EX_RESULT);
      expected[11] = 32'd1;
      drive_instr(rand_instr);
      outputs_match(expected);
    end
    $display("All tests passed");
    $finish;
  end

  // one cycle per vector plus slack for reset and the first edge
  initial begin
    longint limit;
    wait (loaded);
    limit = longint'(num_vectors + RAND_COUNT + 20) * CLK_PERIOD;
    #(limit);
    abort_run($sformatf("timeout, the run did not end within %0d time units", limit));
  end

endmodule

// File: decoder.f
decoder_pkg.sv
mem_access_decoder.sv
control_flow_decoder.sv
alu_op_decoder.sv
system_decoder.sv
decoder.sv
tb_decoder.sv

// File: Makefile
# Verilator build and run of the decoder testbench
VERILATOR ?= verilator
TOP       ?= tb_decoder
FLIST     ?= decoder.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

# the binary exits non-zero on $fatal, so make reports the failure
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: decoder_input.txt
# instr a_sel b_sel alu_op csr_op csr_we mem_req mem_we mem_size gpr_we wb_sel
# illegal branch jal jalr mret, every column in hex, one vector per line
00010083 0 1 00 0 0 1 0 0 1 1 0 0 0 0 0
00011083 0 1 00 0 0 1 0 1 1 1 0 0 0 0 0
00012083 0 1 00 0 0 1 0 2 1 1 0 0 0 0 0
00014083 0 1 00 0 0 1 0 4 1 1 0 0 0 0 0
00015083 0 1 00 0 0 1 0 5 1 1 0 0 0 0 0
00013083 0 1 00 0 0 0 0 0 0 1 1 0 0 0 0
00016083 0 1 00 0 0 0 0 0 0 1 1 0 0 0 0
00310023 0 3 00 0 0 1 1 0 0 0 0 0 0 0 0
00311023 0 3 00 0 0 1 1 1 0 0 0 0 0 0 0
00312023 0 3 00 0 0 1 1 2 0 0 0 0 0 0 0
00313023 0 3 00 0 0 0 0 0 0 0 1 0 0 0 0
00314023 0 3 00 0 0 0 0 0 0 0 1 0 0 0 0
00310063 0 0 18 0 0 0 0 0 0 0 0 1 0 0 0
00311063 0 0 19 0 0 0 0 0 0 0 0 1 0 0 0
00314063 0 0 1c 0 0 0 0 0 0 0 0 1 0 0 0
00315063 0 0 1d 0 0 0 0 0 0 0 0 1 0 0 0
00316063 0 0 1e 0 0 0 0 0 0 0 0 1 0 0 0
00317063 0 0 1f 0 0 0 0 0 0 0 0 1 0 0 0
00312063 0 0 1a 0 0 0 0 0 0 0 1 0 0 0 0
00313063 0 0 1b 0 0 0 0 0 0 0 1 0 0 0 0
000000ef 1 4 00 0 0 0 0 0 1 0 0 0 1 0 0
123450ef 1 4 00 0 0 0 0 0 1 0 0 0 1 0 0
000100e7 1 4 00 0 0 0 0 0 1 0 0 0 0 1 0
000110e7 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
003100b3 0 0 00 0 0 0 0 0 1 0 0 0 0 0 0
003110b3 0 0 01 0 0 0 0 0 1 0 0 0 0 0 0
003120b3 0 0 02 0 0 0 0 0 1 0 0 0 0 0 0
003130b3 0 0 03 0 0 0 0 0 1 0 0 0 0 0 0
003140b3 0 0 04 0 0 0 0 0 1 0 0 0 0 0 0
003150b3 0 0 05 0 0 0 0 0 1 0 0 0 0 0 0
003160b3 0 0 06 0 0 0 0 0 1 0 0 0 0 0 0
003170b3 0 0 07 0 0 0 0 0 1 0 0 0 0 0 0
403100b3 0 0 08 0 0 0 0 0 1 0 0 0 0 0 0
403150b3 0 0 0d 0 0 0 0 0 1 0 0 0 0 0 0
403110b3 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
023100b3 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
00510093 0 1 00 0 0 0 0 0 1 0 0 0 0 0 0
00512093 0 1 02 0 0 0 0 0 1 0 0 0 0 0 0
00513093 0 1 03 0 0 0 0 0 1 0 0 0 0 0 0
fff14093 0 1 04 0 0 0 0 0 1 0 0 0 0 0 0
00516093 0 1 06 0 0 0 0 0 1 0 0 0 0 0 0
0ff17093 0 1 07 0 0 0 0 0 1 0 0 0 0 0 0
00311093 0 1 01 0 0 0 0 0 1 0 0 0 0 0 0
00315093 0 1 05 0 0 0 0 0 1 0 0 0 0 0 0
40315093 0 1 0d 0 0 0 0 0 1 0 0 0 0 0 0
40010093 0 1 00 0 0 0 0 0 1 0 0 0 0 0 0
40311093 0 1 00 0 0 0 0 0 0 0 1 0 0 0 0
02315093 0 1 00 0 0 0 0 0 0 0 1 0 0 0 0
123450b7 2 2 00 0 0 0 0 0 1 0 0 0 0 0 0
12345097 1 2 00 0 0 0 0 0 1 0 0 0 0 0 0
0ff0000f 0 1 07 0 0 0 0 0 0 0 0 0 0 0 0
0000100f 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
300110f3 0 0 00 1 1 0 0 0 1 2 0 0 0 0 0
300120f3 0 0 00 2 1 0 0 0 1 2 0 0 0 0 0
300130f3 0 0 00 3 1 0 0 0 1 2 0 0 0 0 0
300150f3 0 0 00 5 1 0 0 0 1 2 0 0 0 0 0
300160f3 0 0 00 6 1 0 0 0 1 2 0 0 0 0 0
300170f3 0 0 00 7 1 0 0 0 1 2 0 0 0 0 0
300140f3 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
30200073 0 0 00 0 0 0 0 0 0 0 0 0 0 0 1
00000073 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
00100073 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
302000f3 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
0000000b 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
ffffffff 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
00510090 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
00510092 0 0 00 0 0 0 0 0 0 0 1 0 0 0 0
